// File: Makefile
SIM        = verilator
SIM_FLAGS  = --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS = --lint-only --timing --timescale 1ns/1ps
TOP        = debug_scan_tb
FILELIST   = compile.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: compile.f
+incdir+source
source/jtag_pkg.sv
source/scan_pin_sync.sv
source/tap_controller.sv
source/scan_register_bank.sv
source/debug_field_map.sv
source/debug_scan_top.sv
test/debug_scan_tb.sv

// File: source/debug_field_map.sv
`timescale 1ns/1ps
`include "jtag_config.svh"

module debug_field_map import jtag_pkg::*; (
	input  logic                          clk,
	input  logic                          rst_i,
	input  scan_word_t                    cfg_i,
	input  logic [`JTAG_STAT_PHASE_W-1:0] phase_est_i,
	input  logic [`JTAG_STAT_ERR_W-1:0]   prbs_err_cnt_i,
	output scan_word_t                    status_o,
	output logic [`JTAG_CFG_IBUF_W-1:0]   disable_ibuf_o,
	output logic                          blk_rst_o,
	output logic                          cal_start_o,
	output gain_t                         cdr_kp_o,
	output gain_t                         cdr_ki_o,
	output prbs_sel_t                     prbs_sel_o
);

	logic blk_rst_q;
	logic cal_bit_q;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			disable_ibuf_o <= '0;
			blk_rst_q      <= 1'b0;
			cdr_kp_o       <= '0;
			cdr_ki_o       <= '0;
			prbs_sel_o     <= '0;
			cal_bit_q      <= 1'b0;
			cal_start_o    <= 1'b0;
		end else begin
			disable_ibuf_o <= cfg_i[`JTAG_CFG_IBUF_LSB +: `JTAG_CFG_IBUF_W];
			blk_rst_q      <= cfg_i[`JTAG_CFG_BLK_RST_BIT];
			cdr_kp_o       <= cfg_i[`JTAG_CFG_KP_LSB +: `JTAG_GAIN_W];
			cdr_ki_o       <= cfg_i[`JTAG_CFG_KI_LSB +: `JTAG_GAIN_W];
			prbs_sel_o     <= cfg_i[`JTAG_CFG_PRBS_LSB +: `JTAG_PRBS_SEL_W];
			// Start pulse on rising cal bit
			cal_bit_q      <= cfg_i[`JTAG_CFG_CAL_BIT];
			cal_start_o    <= cfg_i[`JTAG_CFG_CAL_BIT] & ~cal_bit_q;
		end
	end

	// Block held in reset by either source
	assign blk_rst_o = rst_i | blk_rst_q;

	always_ff @(posedge clk) begin
		status_o[`JTAG_STAT_PHASE_LSB +: `JTAG_STAT_PHASE_W] <= phase_est_i;
		status_o[`JTAG_STAT_ERR_LSB +: `JTAG_STAT_ERR_W]     <= prbs_err_cnt_i;
	end

	a_cal_single: assert property (@(posedge clk) disable iff (rst_i)
		cal_start_o |=> !cal_start_o);

endmodule

// File: source/debug_scan_top.sv
`timescale 1ns/1ps
`include "jtag_config.svh"

module debug_scan_top import jtag_pkg::*; (
	input  logic                          clk,
	input  logic                          rst_i,
	input  logic                          tck_i,
	input  logic                          tms_i,
	input  logic                          tdi_i,
	input  logic                          trst_i,
	output logic                          tdo_o,
	input  logic [`JTAG_STAT_PHASE_W-1:0] phase_est_i,
	input  logic [`JTAG_STAT_ERR_W-1:0]   prbs_err_cnt_i,
	output logic [`JTAG_CFG_IBUF_W-1:0]   disable_ibuf_o,
	output logic                          blk_rst_o,
	output logic                          cal_start_o,
	output gain_t                         cdr_kp_o,
	output gain_t                         cdr_ki_o,
	output prbs_sel_t                     prbs_sel_o
);

	logic       tck_rise;
	logic       tck_fall;
	logic       tms_sync;
	logic       tdi_sync;
	logic       trst_sync;
	tap_state_t tap_state;
	ir_t        ir;
	scan_word_t cfg_word;
	scan_word_t status_word;

	scan_pin_sync u_pin_sync (
		.clk        (clk),
		.rst_i      (rst_i),
		.tck_i      (tck_i),
		.tms_i      (tms_i),
		.tdi_i      (tdi_i),
		.trst_i     (trst_i),
		.tck_rise_o (tck_rise),
		.tck_fall_o (tck_fall),
		.tms_o      (tms_sync),
		.tdi_o      (tdi_sync),
		.trst_o     (trst_sync)
	);

	tap_controller u_tap (
		.clk        (clk),
		.rst_i      (rst_i),
		.tck_rise_i (tck_rise),
		.tck_fall_i (tck_fall),
		.tms_i      (tms_sync),
		.tdi_i      (tdi_sync),
		.trst_i     (trst_sync),
		.state_o    (tap_state),
		.ir_o       (ir)
	);

	scan_register_bank u_regs (
		.clk        (clk),
		.rst_i      (rst_i),
		.tck_rise_i (tck_rise),
		.tck_fall_i (tck_fall),
		.tdi_i      (tdi_sync),
		.state_i    (tap_state),
		.ir_i       (ir),
		.status_i   (status_word),
		.cfg_o      (cfg_word),
		.tdo_o      (tdo_o)
	);

	debug_field_map u_fields (
		.clk            (clk),
		.rst_i          (rst_i),
		.cfg_i          (cfg_word),
		.phase_est_i    (phase_est_i),
		.prbs_err_cnt_i (prbs_err_cnt_i),
		.status_o       (status_word),
		.disable_ibuf_o (disable_ibuf_o),
		.blk_rst_o      (blk_rst_o),
		.cal_start_o    (cal_start_o),
		.cdr_kp_o       (cdr_kp_o),
		.cdr_ki_o       (cdr_ki_o),
		.prbs_sel_o     (prbs_sel_o)
	);

endmodule

// File: source/jtag_config.svh
`ifndef JTAG_CONFIG_SVH
`define JTAG_CONFIG_SVH

// Instruction register and data word
`define JTAG_IR_WIDTH      4
`define JTAG_WORD_WIDTH    32
`define JTAG_IR_IDCODE     4'h1
`define JTAG_IR_CFG        4'h2
`define JTAG_IR_STATUS     4'h3
`define JTAG_IR_BYPASS     4'hF
`define JTAG_IR_CAPTURE    4'b0001
`define JTAG_IDCODE_VALUE  32'h1A5E_0001

// Config word fields
`define JTAG_CFG_IBUF_LSB     0
`define JTAG_CFG_IBUF_W       4
`define JTAG_CFG_BLK_RST_BIT  4
`define JTAG_CFG_CAL_BIT      5
`define JTAG_CFG_KP_LSB       8
`define JTAG_CFG_KI_LSB       12
`define JTAG_GAIN_W           4
`define JTAG_CFG_PRBS_LSB     16
`define JTAG_PRBS_SEL_W       3

// Status word layout
`define JTAG_STAT_PHASE_LSB   0
`define JTAG_STAT_PHASE_W     16
`define JTAG_STAT_ERR_LSB     16
`define JTAG_STAT_ERR_W       16

`endif

// File: source/jtag_pkg.sv
`include "jtag_config.svh"

package jtag_pkg;

	// Standard 1149.1 state encoding
	typedef enum logic [3:0] {
		exit2_dr         = 4'h0,
		exit1_dr         = 4'h1,
		shift_dr         = 4'h2,
		pause_dr         = 4'h3,
		select_ir        = 4'h4,
		update_dr        = 4'h5,
		capture_dr       = 4'h6,
		select_dr        = 4'h7,
		exit2_ir         = 4'h8,
		exit1_ir         = 4'h9,
		shift_ir         = 4'hA,
		pause_ir         = 4'hB,
		run_idle         = 4'hC,
		update_ir        = 4'hD,
		capture_ir       = 4'hE,
		test_logic_reset = 4'hF
	} tap_state_t;

	typedef logic [`JTAG_IR_WIDTH-1:0]   ir_t;
	typedef logic [`JTAG_WORD_WIDTH-1:0] scan_word_t;
	typedef logic [`JTAG_GAIN_W-1:0]     gain_t;
	typedef logic [`JTAG_PRBS_SEL_W-1:0] prbs_sel_t;

endpackage

// File: source/scan_pin_sync.sv
`timescale 1ns/1ps

module scan_pin_sync (
	input  logic clk,
	input  logic rst_i,
	input  logic tck_i,
	input  logic tms_i,
	input  logic tdi_i,
	input  logic trst_i,
	output logic tck_rise_o,
	output logic tck_fall_o,
	output logic tms_o,
	output logic tdi_o,
	output logic trst_o
);

	// Pins packed as {trst, tdi, tms, tck}
	logic [3:0] pin_s1;
	logic [3:0] pin_s2;
	logic       tck_q;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			pin_s1 <= '0;
			pin_s2 <= '0;
		end else begin
			pin_s1 <= {trst_i, tdi_i, tms_i, tck_i};
			pin_s2 <= pin_s1;
		end
	end

	// Edge stage, levels are delayed to stay aligned with the strobes
	always_ff @(posedge clk) begin
		if (rst_i) begin
			tck_q      <= 1'b0;
			tck_rise_o <= 1'b0;
			tck_fall_o <= 1'b0;
			tms_o      <= 1'b0;
			tdi_o      <= 1'b0;
			trst_o     <= 1'b0;
		end else begin
			tck_q      <= pin_s2[0];
			tck_rise_o <= pin_s2[0] & ~tck_q;
			tck_fall_o <= ~pin_s2[0] & tck_q;
			tms_o      <= pin_s2[1];
			tdi_o      <= pin_s2[2];
			trst_o     <= pin_s2[3];
		end
	end

endmodule

// File: source/scan_register_bank.sv
`timescale 1ns/1ps
`include "jtag_config.svh"

module scan_register_bank import jtag_pkg::*; (
	input  logic       clk,
	input  logic       rst_i,
	input  logic       tck_rise_i,
	input  logic       tck_fall_i,
	input  logic       tdi_i,
	input  tap_state_t state_i,
	input  ir_t        ir_i,
	input  scan_word_t status_i,
	output scan_word_t cfg_o,
	output logic       tdo_o
);

	scan_word_t data_shift;
	ir_t        ir_shift;
	logic       bypass_q;
	logic       sel_word;
	logic       dr_lsb;

	// IDCODE, CFG and STATUS share one 32-bit shift path
	always_comb begin
		case (ir_i)
			`JTAG_IR_IDCODE: sel_word = 1'b1;
			`JTAG_IR_CFG:    sel_word = 1'b1;
			`JTAG_IR_STATUS: sel_word = 1'b1;
			`JTAG_IR_BYPASS: sel_word = 1'b0;
			// unknown codes fall back to bypass
			default:         sel_word = 1'b0;
		endcase
	end

	assign dr_lsb = sel_word ? data_shift[0] : bypass_q;

	always_ff @(posedge clk) begin
		if (tck_rise_i) begin
			if (state_i == capture_dr) begin
				case (ir_i)
					`JTAG_IR_IDCODE: data_shift <= `JTAG_IDCODE_VALUE;
					`JTAG_IR_CFG:    data_shift <= cfg_o;
					`JTAG_IR_STATUS: data_shift <= status_i;
					default:         bypass_q <= 1'b0;
				endcase
			end else if (state_i == shift_dr) begin
				if (sel_word) begin
					data_shift <= {tdi_i, data_shift[`JTAG_WORD_WIDTH-1:1]};
				end else begin
					bypass_q <= tdi_i;
				end
			end
		end
	end

	// Local copy of the instruction shift path for tdo
	always_ff @(posedge clk) begin
		if (tck_rise_i) begin
			if (state_i == capture_ir) begin
				ir_shift <= `JTAG_IR_CAPTURE;
			end else if (state_i == shift_ir) begin
				ir_shift <= {tdi_i, ir_shift[`JTAG_IR_WIDTH-1:1]};
			end
		end
	end

	// tdo and config load on the falling tck
	always_ff @(posedge clk) begin
		if (rst_i) begin
			cfg_o <= '0;
			tdo_o <= 1'b0;
		end else if (tck_fall_i) begin
			tdo_o <= (state_i == shift_ir) ? ir_shift[0] : dr_lsb;
			if (state_i == update_dr && ir_i == `JTAG_IR_CFG) begin
				cfg_o <= data_shift;
			end
		end
	end

	a_cfg_update_only: assert property (@(posedge clk) disable iff (rst_i)
		!$stable(cfg_o) |-> $past(tck_fall_i) && $past(state_i) == update_dr);

endmodule

// File: source/tap_controller.sv
`timescale 1ns/1ps
`include "jtag_config.svh"

module tap_controller import jtag_pkg::*; (
	input  logic       clk,
	input  logic       rst_i,
	input  logic       tck_rise_i,
	input  logic       tck_fall_i,
	input  logic       tms_i,
	input  logic       tdi_i,
	input  logic       trst_i,
	output tap_state_t state_o,
	output ir_t        ir_o
);

	tap_state_t state_next;
	ir_t        ir_shift;
	logic [2:0] tms_high_cnt;

	always_comb begin
		state_next = state_o;
		case (state_o)
			test_logic_reset: state_next = tms_i ? test_logic_reset : run_idle;
			run_idle:         state_next = tms_i ? select_dr : run_idle;
			select_dr:        state_next = tms_i ? select_ir : capture_dr;
			capture_dr:       state_next = tms_i ? exit1_dr : shift_dr;
			shift_dr:         state_next = tms_i ? exit1_dr : shift_dr;
			exit1_dr:         state_next = tms_i ? update_dr : pause_dr;
			pause_dr:         state_next = tms_i ? exit2_dr : pause_dr;
			exit2_dr:         state_next = tms_i ? update_dr : shift_dr;
			update_dr:        state_next = tms_i ? select_dr : run_idle;
			select_ir:        state_next = tms_i ? test_logic_reset : capture_ir;
			capture_ir:       state_next = tms_i ? exit1_ir : shift_ir;
			shift_ir:         state_next = tms_i ? exit1_ir : shift_ir;
			exit1_ir:         state_next = tms_i ? update_ir : pause_ir;
			pause_ir:         state_next = tms_i ? exit2_ir : pause_ir;
			exit2_ir:         state_next = tms_i ? update_ir : shift_ir;
			update_ir:        state_next = tms_i ? select_dr : run_idle;
			default:          state_next = test_logic_reset;
		endcase
	end

	// trst is already synchronized, so it acts as a plain sync reset
	always_ff @(posedge clk) begin
		if (rst_i || trst_i) begin
			state_o <= test_logic_reset;
		end else if (tck_rise_i) begin
			state_o <= state_next;
		end
	end

	// IR shift path, LSB first
	always_ff @(posedge clk) begin
		if (tck_rise_i) begin
			if (state_o == capture_ir) begin
				ir_shift <= `JTAG_IR_CAPTURE;
			end else if (state_o == shift_ir) begin
				ir_shift <= {tdi_i, ir_shift[`JTAG_IR_WIDTH-1:1]};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i || trst_i || state_o == test_logic_reset) begin
			ir_o <= `JTAG_IR_IDCODE;
		end else if (tck_fall_i && state_o == update_ir) begin
			ir_o <= ir_shift;
		end
	end

	// Run of rise strobes with tms high, saturating at five
	always_ff @(posedge clk) begin
		if (rst_i) begin
			tms_high_cnt <= '0;
		end else if (tck_rise_i) begin
			if (!tms_i) begin
				tms_high_cnt <= '0;
			end else if (tms_high_cnt != 3'd5) begin
				tms_high_cnt <= tms_high_cnt + 3'd1;
			end
		end
	end

	a_tms_reset: assert property (@(posedge clk) disable iff (rst_i)
		tms_high_cnt == 3'd5 |-> state_o == test_logic_reset);

endmodule

// File: test/debug_scan_tb.sv
`timescale 1ns/1ps
`include "jtag_config.svh"

module debug_scan_tb import jtag_pkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int TCK_HALF   = 8;
	localparam int WORD_W     = `JTAG_WORD_WIDTH;
	// 43 scans of at most WORD_W + 7 tck periods, plus reset and trst margin
	localparam int WATCHDOG_NS = (43 * (WORD_W + 7) * 2 * TCK_HALF + 200) * CLK_PERIOD;
	localparam scan_word_t CAL_MASK = 1 << `JTAG_CFG_CAL_BIT;

	logic                          clk;
	logic                          rst_i;
	logic                          tck_i;
	logic                          tms_i;
	logic                          tdi_i;
	logic                          trst_i;
	logic                          tdo_o;
	logic [`JTAG_STAT_PHASE_W-1:0] phase_est_i;
	logic [`JTAG_STAT_ERR_W-1:0]   prbs_err_cnt_i;
	logic [`JTAG_CFG_IBUF_W-1:0]   disable_ibuf_o;
	logic                          blk_rst_o;
	logic                          cal_start_o;
	gain_t                         cdr_kp_o;
	gain_t                         cdr_ki_o;
	prbs_sel_t                     prbs_sel_o;

	// Reference model
	ir_t        model_ir       = `JTAG_IR_IDCODE;
	scan_word_t model_cfg      = '0;
	int         exp_cal_pulses = 0;
	int         cal_pulses     = 0;
	int         error_count    = 0;
	int         check_count    = 0;
	integer     seed           = 32'he639_e8ab;

	debug_scan_top u_debug_scan_top (
		.clk            (clk),
		.rst_i          (rst_i),
		.tck_i          (tck_i),
		.tms_i          (tms_i),
		.tdi_i          (tdi_i),
		.trst_i         (trst_i),
		.tdo_o          (tdo_o),
		.phase_est_i    (phase_est_i),
		.prbs_err_cnt_i (prbs_err_cnt_i),
		.disable_ibuf_o (disable_ibuf_o),
		.blk_rst_o      (blk_rst_o),
		.cal_start_o    (cal_start_o),
		.cdr_kp_o       (cdr_kp_o),
		.cdr_ki_o       (cdr_ki_o),
		.prbs_sel_o     (prbs_sel_o)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(negedge clk) begin
		if (cal_start_o === 1'b1) begin
			cal_pulses++;
		end
	end

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	function automatic scan_word_t rand_word();
		return $random(seed);
	endfunction

	// One tck period, tdo sampled just before the rising edge
	task automatic tck_cycle(input logic tms, input logic tdi, output logic tdo);
		tms_i = tms;
		tdi_i = tdi;
		repeat (TCK_HALF) @(negedge clk);
		tdo   = tdo_o;
		tck_i = 1'b1;
		repeat (TCK_HALF) @(negedge clk);
		tck_i = 1'b0;
	endtask

	function automatic scan_word_t expected_dr(input scan_word_t din);
		scan_word_t word;
		word = '0;
		case (model_ir)
			`JTAG_IR_IDCODE: word = `JTAG_IDCODE_VALUE;
			`JTAG_IR_CFG:    word = model_cfg;
			`JTAG_IR_STATUS: begin
				word[`JTAG_STAT_PHASE_LSB +: `JTAG_STAT_PHASE_W] = phase_est_i;
				word[`JTAG_STAT_ERR_LSB +: `JTAG_STAT_ERR_W]     = prbs_err_cnt_i;
			end
			// Bypass bit, a captured zero then tdi one bit late
			default:         word = {din[WORD_W-2:0], 1'b0};
		endcase
		return word;
	endfunction

	task automatic check_fields();
		check_value("disable_ibuf_o", 32'(disable_ibuf_o),
			32'(model_cfg[`JTAG_CFG_IBUF_LSB +: `JTAG_CFG_IBUF_W]));
		check_value("blk_rst_o", 32'(blk_rst_o), 32'(model_cfg[`JTAG_CFG_BLK_RST_BIT]));
		check_value("cdr_kp_o", 32'(cdr_kp_o), 32'(model_cfg[`JTAG_CFG_KP_LSB +: `JTAG_GAIN_W]));
		check_value("cdr_ki_o", 32'(cdr_ki_o), 32'(model_cfg[`JTAG_CFG_KI_LSB +: `JTAG_GAIN_W]));
		check_value("prbs_sel_o", 32'(prbs_sel_o),
			32'(model_cfg[`JTAG_CFG_PRBS_LSB +: `JTAG_PRBS_SEL_W]));
		check_value("cal_start_o", 32'(cal_start_o), 32'h0);
		check_value("cal_start_o pulses", cal_pulses, exp_cal_pulses);
	endtask

	task automatic scan_ir(input ir_t code);
		ir_t  captured;
		logic tdo;
		tck_cycle(1'b0, 1'b0, tdo);
		tck_cycle(1'b1, 1'b0, tdo);
		tck_cycle(1'b1, 1'b0, tdo);
		tck_cycle(1'b0, 1'b0, tdo);
		tck_cycle(1'b0, 1'b0, tdo);
		for (int i = 0; i < `JTAG_IR_WIDTH; i++) begin
			tck_cycle(i == `JTAG_IR_WIDTH - 1, code[i], tdo);
			captured[i] = tdo;
		end
		tck_cycle(1'b1, 1'b0, tdo);
		tck_cycle(1'b0, 1'b0, tdo);
		check_value("tdo_o ir capture", 32'(captured), 32'(`JTAG_IR_CAPTURE));
		model_ir = code;
	endtask

	// Idle, select, capture, shift nbits LSB first, update, idle
	task automatic scan_dr(input scan_word_t din, input int nbits);
		scan_word_t dout;
		scan_word_t expected;
		scan_word_t mask;
		logic       tdo;
		expected = expected_dr(din);
		mask     = {WORD_W{1'b1}} >> (WORD_W - nbits);
		dout     = '0;
		tck_cycle(1'b0, 1'b0, tdo);
		tck_cycle(1'b1, 1'b0, tdo);
		tck_cycle(1'b0, 1'b0, tdo);
		tck_cycle(1'b0, 1'b0, tdo);
		for (int i = 0; i < nbits; i++) begin
			tck_cycle(i == nbits - 1, din[i], tdo);
			dout[i] = tdo;
		end
		tck_cycle(1'b1, 1'b0, tdo);
		tck_cycle(1'b0, 1'b0, tdo);
		check_value("tdo_o", dout & mask, expected & mask);
		if (model_ir == `JTAG_IR_CFG) begin
			if ((din & CAL_MASK) != 0 && (model_cfg & CAL_MASK) == 0) begin
				exp_cal_pulses++;
			end
			model_cfg = din;
		end
		check_fields();
	endtask

	initial begin
		scan_word_t word;
		ir_t        code;
		logic       tdo;
		clk            = 1'b0;
		rst_i          = 1'b1;
		tck_i          = 1'b0;
		tms_i          = 1'b0;
		tdi_i          = 1'b0;
		trst_i         = 1'b0;
		phase_est_i    = '0;
		prbs_err_cnt_i = '0;
		repeat (5) @(negedge clk);
		check_value("blk_rst_o", 32'(blk_rst_o), 32'h1);
		rst_i = 1'b0;
		repeat (2) @(negedge clk);
		check_fields();

		// IDCODE selected straight out of reset
		scan_dr(rand_word(), WORD_W);

		scan_ir(`JTAG_IR_CFG);
		repeat (20) scan_dr(rand_word(), WORD_W);

		scan_ir(`JTAG_IR_STATUS);
		repeat (6) begin
			word           = rand_word();
			phase_est_i    = word[15:0];
			prbs_err_cnt_i = word[31:16];
			scan_dr(rand_word(), WORD_W);
		end

		scan_ir(`JTAG_IR_BYPASS);
		scan_dr(rand_word(), 16);
		do begin
			word = rand_word();
			code = word[`JTAG_IR_WIDTH-1:0];
		end while (code == `JTAG_IR_IDCODE || code == `JTAG_IR_CFG ||
			code == `JTAG_IR_STATUS || code == `JTAG_IR_BYPASS);
		scan_ir(code);
		scan_dr(rand_word(), 16);

		// Into shift_dr, then five tms-high tcks to test_logic_reset
		scan_ir(`JTAG_IR_BYPASS);
		tck_cycle(1'b0, 1'b0, tdo);
		tck_cycle(1'b1, 1'b0, tdo);
		tck_cycle(1'b0, 1'b0, tdo);
		tck_cycle(1'b0, 1'b0, tdo);
		repeat (5) tck_cycle(1'b1, 1'b0, tdo);
		model_ir = `JTAG_IR_IDCODE;
		scan_dr(rand_word(), WORD_W);

		scan_ir(`JTAG_IR_STATUS);
		trst_i = 1'b1;
		repeat (TCK_HALF) @(negedge clk);
		trst_i = 1'b0;
		repeat (TCK_HALF) @(negedge clk);
		model_ir = `JTAG_IR_IDCODE;
		scan_dr(rand_word(), WORD_W);

		// Cal start set, held, cleared, set again
		scan_ir(`JTAG_IR_CFG);
		repeat (2) scan_dr(rand_word() | CAL_MASK, WORD_W);
		scan_dr(rand_word() & ~CAL_MASK, WORD_W);
		scan_dr(rand_word() | CAL_MASK, WORD_W);

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the scan sequence did not finish within %0d ns", WATCHDOG_NS);
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		$display("Testbench failed");
		$finish;
	end

endmodule
